//--- src/adc_pkg.sv
package adc_pkg;

	localparam int CLK_NS            = 20;	// adc_clk period
	localparam int CONVST_LOW_CYCLES = 2;	// convst low pulse width
	localparam int RD_LOW_CYCLES     = 2;	// rd_n low time per channel
	localparam int RD_HIGH_CYCLES    = 1;	// rd_n high gap between channels
	localparam int CHANNELS          = 8;	// channels per chip

	typedef logic [15:0] sample_t;	// one channel, chip output word

	// ch1 sits in the top bits so a left shift of reads lands in order
	typedef struct packed {
		sample_t ch1;
		sample_t ch2;
		sample_t ch3;
		sample_t ch4;
		sample_t ch5;
		sample_t ch6;
		sample_t ch7;
		sample_t ch8;
	} chip_samples_t;

	typedef struct packed {
		logic [15:0] sampling_period;	// adc_clk cycles per point
		logic [15:0] sampling_points;	// points per acquisition
		logic        last_frame;	// mark last word of last frame
	} acq_config_t;

endpackage

//--- src/stream_pkg.sv
package stream_pkg;

	localparam logic [31:0] FRAME_HEADER = 32'h0000_FFF0;
	localparam logic [31:0] FRAME_TAILER = 32'h0000_FF0F;
	localparam int FRAME_WORDS     = 18;	// header + 16 channels + tailer
	localparam int FIFO_DEPTH      = 32;
	localparam int FIFO_COUNT_BITS = 6;	// holds 0..FIFO_DEPTH

	typedef union packed {
		logic [31:0] raw;	// header / tailer view
		struct packed {
			logic [15:0] sample;	// channel value
			logic [7:0]  crc_hi;	// crc of sample[15:8]
			logic [7:0]  crc_lo;	// crc of sample[7:0]
		} ch;
	} frame_word_t;

	typedef struct packed {
		frame_word_t data;
		logic        last;	// end of final frame
	} stream_beat_t;

	// smbus crc-8, poly 0x07, init 0, no final xor
	function automatic logic [7:0] crc8_smbus(input logic [7:0] din);
		logic [7:0] crc;
		crc = din;	// init 0, so first xor is just the byte
		for (int i = 0; i < 8; i++) begin
			crc = crc[7] ? ((crc << 1) ^ 8'h07) : (crc << 1);
		end
		return crc;
	endfunction

endpackage

//--- src/acq_sequencer.sv
`timescale 1ns/1ps

module acq_sequencer (
	input  logic                 adc_clk,
	input  logic                 adc_rst_n,
	input  logic                 trigger,
	input  adc_pkg::acq_config_t cfg,
	input  logic                 frame_done,
	output logic                 sample_tick,
	output logic                 final_frame,
	output logic                 ready
);
	import adc_pkg::*;

	logic        trig_s1;	// first sync stage
	logic        trig_s2;	// second stage, also edge history
	logic        trig_edge;
	logic        running;
	acq_config_t cfg_q;	// frozen while running
	logic [15:0] period_cnt;	// cycles since last tick
	logic [15:0] ticks_sent;
	logic [15:0] frames_done;
	logic        last_point;

	assign trig_edge   = trig_s1 & ~trig_s2;
	assign last_point  = (frames_done == cfg_q.sampling_points - 16'd1);
	assign final_frame = running & cfg_q.last_frame & last_point;	// level until frame_done

	always_ff @(posedge adc_clk) begin
		if (!adc_rst_n) begin
			trig_s1 <= 1'b0;
			trig_s2 <= 1'b0;
		end else begin
			trig_s1 <= trigger;
			trig_s2 <= trig_s1;
		end
	end

	always_ff @(posedge adc_clk) begin
		if (!running)
			cfg_q <= cfg;	// track config while idle
	end

	always_ff @(posedge adc_clk) begin
		if (!adc_rst_n) begin
			running     <= 1'b0;
			ready       <= 1'b1;
			sample_tick <= 1'b0;
			period_cnt  <= '0;
			ticks_sent  <= '0;
			frames_done <= '0;
		end else begin
			sample_tick <= 1'b0;
			if (!running) begin
				if (trig_edge && cfg.sampling_points != 16'd0) begin
					running     <= 1'b1;
					ready       <= 1'b0;
					sample_tick <= 1'b1;	// first point right away
					ticks_sent  <= 16'd1;
					period_cnt  <= '0;
					frames_done <= '0;
				end
			end else begin
				if (ticks_sent != cfg_q.sampling_points) begin	// more points to start
					if (period_cnt == cfg_q.sampling_period - 16'd1) begin
						sample_tick <= 1'b1;
						ticks_sent  <= ticks_sent + 16'd1;
						period_cnt  <= '0;
					end else begin
						period_cnt <= period_cnt + 16'd1;
					end
				end
				if (frame_done) begin
					frames_done <= frames_done + 16'd1;
					if (last_point) begin	// acquisition complete
						running <= 1'b0;
						ready   <= 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- src/ad7606_reader.sv
`timescale 1ns/1ps

module ad7606_reader (
	input  logic                   adc_clk,
	input  logic                   adc_rst_n,
	input  logic                   sample_tick,
	input  logic                   busy,
	input  adc_pkg::sample_t       data,
	output logic                   convst,
	output logic                   cs_n,
	output logic                   rd_n,
	output adc_pkg::chip_samples_t samples,
	output logic                   samples_valid
);
	import adc_pkg::*;

	typedef enum logic [2:0] {
		R_IDLE,
		R_CONV,	// convst held low
		R_BUSY_HI,	// wait for conversion to start
		R_BUSY_LO,	// wait for conversion to end
		R_RD_LO,	// cs_n/rd_n low, data driven by chip
		R_RD_HI	// gap between reads
	} rd_state_t;

	rd_state_t   state;
	logic [3:0]  cnt;	// pulse width counter
	logic [3:0]  ch_cnt;	// channels read so far

	always_ff @(posedge adc_clk) begin
		if (!adc_rst_n) begin
			state         <= R_IDLE;
			cnt           <= '0;
			ch_cnt        <= '0;
			convst        <= 1'b1;
			cs_n          <= 1'b1;
			rd_n          <= 1'b1;
			samples_valid <= 1'b0;
		end else begin
			samples_valid <= 1'b0;
			case (state)
				R_IDLE: begin
					if (sample_tick) begin
						convst <= 1'b0;	// start conversion
						cnt    <= '0;
						state  <= R_CONV;
					end
				end
				R_CONV: begin
					if (cnt == 4'(CONVST_LOW_CYCLES - 1)) begin
						convst <= 1'b1;	// rising edge starts the chip
						state  <= R_BUSY_HI;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				R_BUSY_HI: begin
					if (busy)
						state <= R_BUSY_LO;
				end
				R_BUSY_LO: begin
					if (!busy) begin	// results ready
						cs_n   <= 1'b0;
						rd_n   <= 1'b0;
						cnt    <= '0;
						ch_cnt <= '0;
						state  <= R_RD_LO;
					end
				end
				R_RD_LO: begin
					if (cnt == 4'(RD_LOW_CYCLES - 1)) begin
						cs_n    <= 1'b1;
						rd_n    <= 1'b1;
						samples <= {samples[$bits(chip_samples_t)-$bits(sample_t)-1:0], data};
						ch_cnt  <= ch_cnt + 4'd1;
						cnt     <= '0;
						state   <= R_RD_HI;
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				R_RD_HI: begin
					if (cnt == 4'(RD_HIGH_CYCLES - 1)) begin
						cnt <= '0;
						if (ch_cnt == 4'(CHANNELS)) begin	// all eight in
							samples_valid <= 1'b1;
							state         <= R_IDLE;
						end else begin
							cs_n  <= 1'b0;
							rd_n  <= 1'b0;
							state <= R_RD_LO;
						end
					end else begin
						cnt <= cnt + 4'd1;
					end
				end
				default: state <= R_IDLE;
			endcase
		end
	end

endmodule

//--- src/frame_packer.sv
`timescale 1ns/1ps

module frame_packer (
	input  logic                                   adc_clk,
	input  logic                                   adc_rst_n,
	input  adc_pkg::chip_samples_t                 a_samples,
	input  adc_pkg::chip_samples_t                 b_samples,
	input  logic                                   a_valid,
	input  logic                                   b_valid,
	input  logic                                   final_frame,
	input  logic                                   seq_ready,
	input  logic [stream_pkg::FIFO_COUNT_BITS-1:0] fifo_count,
	output logic                                   wr_en,
	output stream_pkg::stream_beat_t               wr_beat,
	output logic                                   frame_done,
	output logic                                   overflow
);
	import adc_pkg::*;
	import stream_pkg::*;

	chip_samples_t                a_q;	// chip a samples, held for the frame
	chip_samples_t                b_q;
	sample_t [CHANNELS-1:0]       a_arr;	// index 7 is ch1
	sample_t [CHANNELS-1:0]       b_arr;
	logic                         a_have;
	logic                         b_have;
	logic                         writing;
	logic                         ready_d;	// falling ready marks a new acquisition
	logic [4:0]                   word_idx;	// next word, 1..17 while writing
	logic [3:0]                   ch_idx;	// 0..7 chip a, 8..15 chip b
	logic [FIFO_COUNT_BITS-1:0]   free_words;
	sample_t                      cur_sample;
	frame_word_t                  ch_word;

	assign a_arr      = a_q;
	assign b_arr      = b_q;
	assign ch_idx     = 4'(word_idx - 5'd1);
	assign free_words = FIFO_COUNT_BITS'(FIFO_DEPTH) - fifo_count;
	assign cur_sample = ch_idx[3] ? b_arr[~ch_idx[2:0]] : a_arr[~ch_idx[2:0]];	// ~ maps ch1 to 7

	always_comb begin
		ch_word.ch.sample = cur_sample;
		ch_word.ch.crc_hi = crc8_smbus(cur_sample[15:8]);
		ch_word.ch.crc_lo = crc8_smbus(cur_sample[7:0]);
	end

	always_ff @(posedge adc_clk) begin
		if (a_valid)
			a_q <= a_samples;
		if (b_valid)
			b_q <= b_samples;
	end

	always_ff @(posedge adc_clk) begin
		if (!adc_rst_n) begin
			a_have     <= 1'b0;
			b_have     <= 1'b0;
			writing    <= 1'b0;
			ready_d    <= 1'b1;
			word_idx   <= '0;
			wr_en      <= 1'b0;
			frame_done <= 1'b0;
			overflow   <= 1'b0;
		end else begin
			wr_en      <= 1'b0;
			frame_done <= 1'b0;
			ready_d    <= seq_ready;
			if (ready_d && !seq_ready)
				overflow <= 1'b0;	// cleared by next trigger
			if (writing) begin
				wr_en        <= 1'b1;
				wr_beat.last <= 1'b0;
				if (word_idx == 5'(FRAME_WORDS - 1)) begin
					wr_beat.data.raw <= FRAME_TAILER;
					wr_beat.last     <= final_frame;
					frame_done       <= 1'b1;
					writing          <= 1'b0;
				end else begin
					wr_beat.data <= ch_word;
					word_idx     <= word_idx + 5'd1;
				end
			end else if (a_have && b_have) begin
				a_have <= 1'b0;
				b_have <= 1'b0;
				if (free_words >= FIFO_COUNT_BITS'(FRAME_WORDS)) begin	// whole frame fits
					wr_en            <= 1'b1;
					wr_beat.data.raw <= FRAME_HEADER;
					wr_beat.last     <= 1'b0;
					word_idx         <= 5'd1;
					writing          <= 1'b1;
				end else begin
					overflow   <= 1'b1;	// frame dropped
					frame_done <= 1'b1;
				end
			end
			if (a_valid)
				a_have <= 1'b1;
			if (b_valid)
				b_have <= 1'b1;
		end
	end

endmodule

//--- src/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo (
	input  logic                                   adc_clk,
	input  logic                                   adc_rst_n,
	input  logic                                   wr_en,
	input  stream_pkg::stream_beat_t               wr_beat,
	output stream_pkg::stream_beat_t               out_beat,
	output logic                                   out_valid,
	input  logic                                   out_ready,
	output logic [stream_pkg::FIFO_COUNT_BITS-1:0] count
);
	import stream_pkg::*;

	stream_beat_t               mem [FIFO_DEPTH];
	logic [FIFO_COUNT_BITS-2:0] wr_ptr;	// one bit narrower than count, wraps at depth
	logic [FIFO_COUNT_BITS-2:0] rd_ptr;
	logic                       push;
	logic                       pop;

	assign out_valid = (count != '0);
	assign out_beat  = mem[rd_ptr];	// fall-through read
	assign push      = wr_en && (count != FIFO_COUNT_BITS'(FIFO_DEPTH));
	assign pop       = out_valid && out_ready;

	always_ff @(posedge adc_clk) begin
		if (push)
			mem[wr_ptr] <= wr_beat;
	end

	always_ff @(posedge adc_clk) begin
		if (!adc_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + FIFO_COUNT_BITS'(push) - FIFO_COUNT_BITS'(pop);	// both may happen
		end
	end

endmodule

//--- src/adc_stream_top.sv
`timescale 1ns/1ps

module adc_stream_top (
	input  logic                     adc_clk,
	input  logic                     adc_rst_n,
	input  logic                     trigger,
	input  adc_pkg::acq_config_t     cfg,
	output logic                     ready,
	output logic                     overflow,
	input  logic                     a_busy,
	input  adc_pkg::sample_t         a_data,
	output logic                     a_convst,
	output logic                     a_cs_n,
	output logic                     a_rd_n,
	input  logic                     b_busy,
	input  adc_pkg::sample_t         b_data,
	output logic                     b_convst,
	output logic                     b_cs_n,
	output logic                     b_rd_n,
	output stream_pkg::stream_beat_t out_beat,
	output logic                     out_valid,
	input  logic                     out_ready
);
	import adc_pkg::*;
	import stream_pkg::*;

	logic                       sample_tick;	// shared start for both chips
	logic                       final_frame;
	logic                       frame_done;
	chip_samples_t              a_samples;
	chip_samples_t              b_samples;
	logic                       a_valid;
	logic                       b_valid;
	logic                       wr_en;
	stream_beat_t               wr_beat;
	logic [FIFO_COUNT_BITS-1:0] fifo_count;

	acq_sequencer seq_i (
		.adc_clk     (adc_clk),
		.adc_rst_n   (adc_rst_n),
		.trigger     (trigger),
		.cfg         (cfg),
		.frame_done  (frame_done),
		.sample_tick (sample_tick),
		.final_frame (final_frame),
		.ready       (ready)
	);

	ad7606_reader reader_a (
		.adc_clk       (adc_clk),
		.adc_rst_n     (adc_rst_n),
		.sample_tick   (sample_tick),
		.busy          (a_busy),
		.data          (a_data),
		.convst        (a_convst),
		.cs_n          (a_cs_n),
		.rd_n          (a_rd_n),
		.samples       (a_samples),
		.samples_valid (a_valid)
	);

	ad7606_reader reader_b (
		.adc_clk       (adc_clk),
		.adc_rst_n     (adc_rst_n),
		.sample_tick   (sample_tick),
		.busy          (b_busy),
		.data          (b_data),
		.convst        (b_convst),
		.cs_n          (b_cs_n),
		.rd_n          (b_rd_n),
		.samples       (b_samples),
		.samples_valid (b_valid)
	);

	frame_packer packer_i (
		.adc_clk     (adc_clk),
		.adc_rst_n   (adc_rst_n),
		.a_samples   (a_samples),
		.b_samples   (b_samples),
		.a_valid     (a_valid),
		.b_valid     (b_valid),
		.final_frame (final_frame),
		.seq_ready   (ready),	// falling edge clears overflow
		.fifo_count  (fifo_count),
		.wr_en       (wr_en),
		.wr_beat     (wr_beat),
		.frame_done  (frame_done),
		.overflow    (overflow)
	);

	frame_fifo fifo_i (
		.adc_clk   (adc_clk),
		.adc_rst_n (adc_rst_n),
		.wr_en     (wr_en),
		.wr_beat   (wr_beat),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.count     (fifo_count)
	);

endmodule

//--- verif/ad7606_model.sv
`timescale 1ns/1ps

module ad7606_model #(
	parameter int BUSY_DELAY  = 1,	// cycles from convst rise to busy
	parameter int BUSY_CYCLES = 4	// conversion time
) (
	input  logic             adc_clk,
	input  logic             convst,
	input  logic             rd_n,
	output logic             busy,
	output adc_pkg::sample_t data
);
	import adc_pkg::*;

	sample_t sent_q[$];	// values driven, oldest first
	sample_t next_val;

	initial begin
		busy     = 1'b0;
		data     = '0;
		next_val = '0;
	end

	// conversion starts on the convst rising edge
	always @(posedge convst) begin
		repeat (BUSY_DELAY) @(posedge adc_clk);
		busy <= 1'b1;
		repeat (BUSY_CYCLES) @(posedge adc_clk);
		busy <= 1'b0;	// results ready
	end

	// next channel word on each rd_n fall
	always @(negedge rd_n) begin
		next_val = sample_t'($urandom);
		data <= next_val;
		sent_q.push_back(next_val);	// tb pops these as expected samples
	end

endmodule

//--- verif/adc_stream_properties.sv
`timescale 1ns/1ps

module adc_stream_properties (
	input logic                     adc_clk,
	input logic                     adc_rst_n,
	input logic                     a_busy,
	input logic                     a_convst,
	input logic                     a_cs_n,
	input logic                     a_rd_n,
	input logic                     b_busy,
	input logic                     b_convst,
	input logic                     b_cs_n,
	input logic                     b_rd_n,
	input stream_pkg::stream_beat_t out_beat,
	input logic                     out_valid,
	input logic                     out_ready
);
	import adc_pkg::*;

	logic [3:0] a_low_cnt;	// cycles convst has been low
	logic [3:0] b_low_cnt;

	always_ff @(posedge adc_clk) begin
		if (!adc_rst_n || a_convst)
			a_low_cnt <= '0;
		else
			a_low_cnt <= a_low_cnt + 4'd1;
		if (!adc_rst_n || b_convst)
			b_low_cnt <= '0;
		else
			b_low_cnt <= b_low_cnt + 4'd1;
	end

	a_no_read_in_conv: assert property (@(posedge adc_clk) disable iff (!adc_rst_n)
		a_busy |-> a_cs_n && a_rd_n) else $error("chip A read strobed while busy");
	b_no_read_in_conv: assert property (@(posedge adc_clk) disable iff (!adc_rst_n)
		b_busy |-> b_cs_n && b_rd_n) else $error("chip B read strobed while busy");

	a_convst_width: assert property (@(posedge adc_clk) disable iff (!adc_rst_n)
		$rose(a_convst) |-> a_low_cnt == 4'(CONVST_LOW_CYCLES))
		else $error("chip A convst low pulse has the wrong width");
	b_convst_width: assert property (@(posedge adc_clk) disable iff (!adc_rst_n)
		$rose(b_convst) |-> b_low_cnt == 4'(CONVST_LOW_CYCLES))
		else $error("chip B convst low pulse has the wrong width");

	beat_held: assert property (@(posedge adc_clk) disable iff (!adc_rst_n)
		out_valid && !out_ready |=> $stable(out_beat))
		else $error("out_beat changed while stalled");

endmodule

bind adc_stream_top adc_stream_properties props_i (
	.adc_clk   (adc_clk),
	.adc_rst_n (adc_rst_n),
	.a_busy    (a_busy),
	.a_convst  (a_convst),
	.a_cs_n    (a_cs_n),
	.a_rd_n    (a_rd_n),
	.b_busy    (b_busy),
	.b_convst  (b_convst),
	.b_cs_n    (b_cs_n),
	.b_rd_n    (b_rd_n),
	.out_beat  (out_beat),
	.out_valid (out_valid),
	.out_ready (out_ready)
);

//--- verif/tb_adc_stream.sv
`timescale 1ns/1ps

module tb_adc_stream;
	import adc_pkg::*;
	import stream_pkg::*;

	localparam int CLK_PERIOD_NS = 100;
	localparam int RESET_CYCLES  = 10;
	localparam int PERIOD_CYCLES = 60;	// longer than one conversion plus eight reads
	localparam int TOTAL_POINTS  = 10;	// points over all tests
	localparam int ACQUISITIONS  = 5;
	localparam int TAIL_CYCLES   = 400;	// worst-case conversion, packing and drain
	localparam int WATCHDOG_NS   = (RESET_CYCLES + TOTAL_POINTS * PERIOD_CYCLES
		+ 2 * ACQUISITIONS * TAIL_CYCLES) * CLK_PERIOD_NS;
	localparam logic [31:0] SEED = 32'h9259;

	logic         adc_clk;
	logic         adc_rst_n;
	logic         trigger;
	acq_config_t  cfg;
	logic         ready;
	logic         overflow;
	logic         a_busy;
	sample_t      a_data;
	logic         a_convst;
	logic         a_cs_n;
	logic         a_rd_n;
	logic         b_busy;
	sample_t      b_data;
	logic         b_convst;
	logic         b_cs_n;
	logic         b_rd_n;
	stream_beat_t out_beat;
	logic         out_valid;
	logic         out_ready;
	stream_beat_t rx_q[$];	// accepted beats
	stream_beat_t exp_q[$];	// expected beats

	adc_stream_top dut_i (
		.adc_clk   (adc_clk),
		.adc_rst_n (adc_rst_n),
		.trigger   (trigger),
		.cfg       (cfg),
		.ready     (ready),
		.overflow  (overflow),
		.a_busy    (a_busy),
		.a_data    (a_data),
		.a_convst  (a_convst),
		.a_cs_n    (a_cs_n),
		.a_rd_n    (a_rd_n),
		.b_busy    (b_busy),
		.b_data    (b_data),
		.b_convst  (b_convst),
		.b_cs_n    (b_cs_n),
		.b_rd_n    (b_rd_n),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

	ad7606_model model_a (
		.adc_clk (adc_clk),
		.convst  (a_convst),
		.rd_n    (a_rd_n),
		.busy    (a_busy),
		.data    (a_data)
	);

	ad7606_model model_b (
		.adc_clk (adc_clk),
		.convst  (b_convst),
		.rd_n    (b_rd_n),
		.busy    (b_busy),
		.data    (b_data)
	);

	initial adc_clk = 1'b0;
	always #(CLK_PERIOD_NS / 2) adc_clk = ~adc_clk;

	// transfers seen like a flop would see them
	always @(posedge adc_clk) begin
		if (adc_rst_n && out_valid && out_ready)
			rx_q.push_back(out_beat);
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
		stop_on_error($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, want));
	endtask

	// bit-serial, msb first, poly x^8+x^2+x+1
	function automatic logic [7:0] smbus_crc(input logic [7:0] b);
		logic [7:0] crc;
		logic       fb;
		crc = 8'h00;
		for (int i = 7; i >= 0; i--) begin
			fb  = crc[7] ^ b[i];
			crc = {crc[6:0], 1'b0} ^ (fb ? 8'h07 : 8'h00);
		end
		return crc;
	endfunction

	// one frame from the next eight samples of each chip
	task automatic expect_point(input logic last);
		stream_beat_t beat;
		sample_t      s;
		assert (model_a.sent_q.size() >= CHANNELS && model_b.sent_q.size() >= CHANNELS)
			else stop_on_error("a chip model sent fewer samples than one frame needs");
		beat.last     = 1'b0;
		beat.data.raw = FRAME_HEADER;
		exp_q.push_back(beat);
		for (int i = 0; i < 2 * CHANNELS; i++) begin
			if (i < CHANNELS)
				s = model_a.sent_q.pop_front();	// A1..A8
			else
				s = model_b.sent_q.pop_front();	// then B1..B8
			beat.data.ch.sample = s;
			beat.data.ch.crc_hi = smbus_crc(s[15:8]);
			beat.data.ch.crc_lo = smbus_crc(s[7:0]);
			exp_q.push_back(beat);
		end
		beat.data.raw = FRAME_TAILER;
		beat.last     = last;
		exp_q.push_back(beat);
	endtask

	task automatic discard_point();
		repeat (CHANNELS) begin
			void'(model_a.sent_q.pop_front());
			void'(model_b.sent_q.pop_front());
		end
	endtask

	task automatic compare_stream();
		assert (rx_q.size() == exp_q.size())
			else mismatch("stream word count", rx_q.size(), exp_q.size());
		for (int i = 0; i < rx_q.size(); i++) begin
			assert (rx_q[i] === exp_q[i])
				else mismatch($sformatf("out_beat[%0d]", i), rx_q[i], exp_q[i]);
		end
		rx_q.delete();
		exp_q.delete();
	endtask

	task automatic start_acquisition(input int points, input logic last);
		int waited;
		waited = 0;
		@(negedge adc_clk);
		cfg.sampling_period = 16'(PERIOD_CYCLES);
		cfg.sampling_points = 16'(points);
		cfg.last_frame      = last;
		trigger             = 1'b1;
		while (ready) begin
			@(negedge adc_clk);
			waited++;
			assert (waited <= 3) else stop_on_error("ready did not fall after the trigger");
		end
		trigger = 1'b0;	// edge already taken
	endtask

	task automatic await_ready(input int points);
		int waited;
		waited = 0;
		while (!ready) begin
			@(negedge adc_clk);	// last frame_done seen
			waited++;
			assert (waited <= points * PERIOD_CYCLES + TAIL_CYCLES)
				else stop_on_error("ready did not return after the last frame");
		end
	endtask

	task automatic drain_fifo();
		int waited;
		waited = 0;
		while (out_valid) begin
			@(negedge adc_clk);	// fifo empty
			waited++;
			assert (waited <= TAIL_CYCLES) else stop_on_error("the FIFO did not drain");
		end
	endtask

	task automatic finish_acquisition(input int points);
		await_ready(points);
		drain_fifo();
	endtask

	task automatic after_reset();
		assert (ready === 1'b1) else mismatch("ready", ready, 1);
		assert (out_valid === 1'b0) else mismatch("out_valid", out_valid, 0);
		assert (overflow === 1'b0) else mismatch("overflow", overflow, 0);
		assert ({a_convst, a_cs_n, a_rd_n} === 3'b111)
			else mismatch("a_convst/a_cs_n/a_rd_n", {a_convst, a_cs_n, a_rd_n}, 3'b111);
		assert ({b_convst, b_cs_n, b_rd_n} === 3'b111)
			else mismatch("b_convst/b_cs_n/b_rd_n", {b_convst, b_cs_n, b_rd_n}, 3'b111);
	endtask

	task automatic one_point_frame();
		start_acquisition(1, 1'b1);
		finish_acquisition(1);
		expect_point(1'b1);
		compare_stream();
	endtask

	task automatic three_point_frames();
		start_acquisition(3, 1'b0);
		finish_acquisition(3);
		repeat (3)
			expect_point(1'b0);
		compare_stream();
	endtask

	task automatic random_backpressure();
		logic toggling;
		toggling = 1'b1;
		fork
			begin
				start_acquisition(2, 1'b1);
				finish_acquisition(2);
				toggling = 1'b0;
			end
			begin
				while (toggling) begin
					@(negedge adc_clk);
					out_ready = 1'($urandom_range(0, 1));
				end
			end
		join
		@(negedge adc_clk);
		out_ready = 1'b1;
		expect_point(1'b0);
		expect_point(1'b1);
		compare_stream();
	endtask

	task automatic overflow_and_clear();
		int kept;
		kept = FIFO_DEPTH / FRAME_WORDS;	// whole frames that fit while stalled
		@(negedge adc_clk);
		out_ready = 1'b0;
		start_acquisition(3, 1'b0);
		await_ready(3);
		assert (overflow === 1'b1) else mismatch("overflow", overflow, 1);
		out_ready = 1'b1;
		drain_fifo();
		assert (rx_q.size() % FRAME_WORDS == 0)
			else stop_on_error("stream after overflow does not hold whole frames");
		for (int p = 0; p < 3; p++) begin
			if (p < kept)
				expect_point(1'b0);
			else
				discard_point();	// frame dropped in the packer
		end
		compare_stream();
		assert (overflow === 1'b1) else mismatch("overflow", overflow, 1);	// sticky while idle
		start_acquisition(1, 1'b0);
		@(negedge adc_clk);	// clear lands one cycle after ready falls
		assert (overflow === 1'b0) else mismatch("overflow", overflow, 0);
		finish_acquisition(1);
		expect_point(1'b0);
		compare_stream();
	endtask

	initial begin
		#(WATCHDOG_NS);
		stop_on_error("watchdog timeout, the tests did not finish in time");
	end

	initial begin
		void'($urandom(SEED));
		adc_rst_n = 1'b0;
		trigger   = 1'b0;
		cfg       = '0;
		out_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge adc_clk);
		adc_rst_n = 1'b1;
		@(negedge adc_clk);
		after_reset();
		one_point_frame();
		three_point_frames();
		random_backpressure();
		overflow_and_clear();
		$display("Simulation passed");
		$finish;
	end

endmodule

//--- list.f
src/adc_pkg.sv
src/stream_pkg.sv
src/acq_sequencer.sv
src/ad7606_reader.sv
src/frame_packer.sv
src/frame_fifo.sv
src/adc_stream_top.sv
verif/ad7606_model.sv
verif/adc_stream_properties.sv
verif/tb_adc_stream.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_stream -f list.f -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "testbench reported failure, see sim.log"
	exit 1
fi
grep -q "Simulation passed" sim.log
